/* source/lbm_pkg.sv */
package lbm_pkg;

    // ----------------------------------------
    // Lattice and number formats
    // ----------------------------------------

    // D2Q9 has one rest population and eight moving ones
    localparam int NUM_DIRS = 9;

    // One distribution value, unsigned
    localparam int DIST_W = 16;

    // Density is unsigned, momentum is two's complement
    // Nine full-scale values still fit without overflow
    localparam int MOM_W = 20;

    // Relaxation rate in 1/256 steps, so 256 means 1.0
    localparam int OMEGA_W = 10;

    // ----------------------------------------
    // Lattice weights
    // ----------------------------------------

    // Fractions of 65536
    // 4/9 for rest, 1/9 along the axes, 1/36 on the diagonals
    localparam logic [15:0] W_REST = 16'd29127;
    localparam logic [15:0] W_AXIS = 16'd7282;
    localparam logic [15:0] W_DIAG = 16'd1820;

    // ----------------------------------------
    // Shared types
    // ----------------------------------------

    typedef logic [DIST_W-1:0] dist_t;

    // One lattice site, rest sits in the top bits
    // Seen as an ascending packed array, slot 0 is rest and slot 8 is nw
    typedef struct packed {
        dist_t rest;
        dist_t n;
        dist_t ne;
        dist_t e;
        dist_t se;
        dist_t s;
        dist_t sw;
        dist_t w;
        dist_t nw;
    } cell_t;

    // Moments of a streamed site
    typedef struct packed {
        logic        [MOM_W-1:0] rho;
        logic signed [MOM_W-1:0] mom_x;
        logic signed [MOM_W-1:0] mom_y;
    } moments_t;

endpackage

/* source/dist_bank_ram.sv */
module dist_bank_ram #(
    parameter  int DEPTH  = 64,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic                clk,
    input  logic                bank,
    input  logic [ADDR_W-1:0]   rd_addr,
    input  logic                wr_en,
    input  logic [ADDR_W-1:0]   wr_addr,
    input  lbm_pkg::dist_t      wr_data,
    output lbm_pkg::dist_t      rd_data
);

    // Ping-pong storage for one lattice direction
    lbm_pkg::dist_t mem0 [DEPTH];
    lbm_pkg::dist_t mem1 [DEPTH];

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    // Always lands in the bank that is not being read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (bank) begin
                mem0[wr_addr] <= wr_data;
            end else begin
                mem1[wr_addr] <= wr_data;
            end
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= bank ? mem1[rd_addr] : mem0[rd_addr];
    end

endmodule

/* source/dist_store.sv */
module dist_store #(
    parameter  int GRID_W = 8,
    parameter  int GRID_H = 8,
    localparam int DEPTH  = GRID_W * GRID_H,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      load_valid,
    input  lbm_pkg::cell_t                            load_cell,
    input  logic [0:lbm_pkg::NUM_DIRS-1][ADDR_W-1:0]  rd_addr,
    input  logic                                      wb_valid,
    input  logic [ADDR_W-1:0]                         wb_addr,
    input  lbm_pkg::cell_t                            wb_cell,
    input  logic                                      step_done,
    output lbm_pkg::cell_t                            rd_cell
);

    // Current bank, the sweep reads it and writeback fills the other one
    logic              bank_sel;
    logic [ADDR_W-1:0] load_cnt;

    // Controls shared by all nine direction RAMs
    logic              ram_bank;
    logic              ram_wr_en;
    logic [ADDR_W-1:0] ram_wr_addr;

    // Cells seen per direction, slot 0 is rest
    logic [0:lbm_pkg::NUM_DIRS-1][lbm_pkg::DIST_W-1:0] load_vec;
    logic [0:lbm_pkg::NUM_DIRS-1][lbm_pkg::DIST_W-1:0] wb_vec;
    logic [0:lbm_pkg::NUM_DIRS-1][lbm_pkg::DIST_W-1:0] rd_vec;

    assign load_vec = load_cell;
    assign wb_vec   = wb_cell;
    assign rd_cell  = rd_vec;

    // ----------------------------------------
    // Bank select and load counter
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_sel <= 1'b0;
            load_cnt <= '0;
        end else begin
            // Swap at the end of every step
            if (step_done) begin
                bank_sel <= ~bank_sel;
            end
            // Sequential fill, wraps after one full grid
            if (load_valid) begin
                if (load_cnt == ADDR_W'(DEPTH - 1)) begin
                    load_cnt <= '0;
                end else begin
                    load_cnt <= load_cnt + 1'b1;
                end
            end
        end
    end

    // RAM writes go to the bank opposite its bank input
    // so a load flips it to reach the current bank
    assign ram_bank    = load_valid ? ~bank_sel : bank_sel;
    assign ram_wr_en   = load_valid | wb_valid;
    assign ram_wr_addr = load_valid ? load_cnt : wb_addr;

    // ----------------------------------------
    // Direction memories
    // ----------------------------------------

    for (genvar k = 0; k < lbm_pkg::NUM_DIRS; k++) begin : g_dir
        lbm_pkg::dist_t wr_data;

        // Loader has priority, never overlaps a writeback anyway
        assign wr_data = load_valid ? load_vec[k] : wb_vec[k];

        dist_bank_ram #(
            .DEPTH (DEPTH)
        ) u_ram (
            .clk     (clk),
            .bank    (ram_bank),
            .rd_addr (rd_addr[k]),
            .wr_en   (ram_wr_en),
            .wr_addr (ram_wr_addr),
            .wr_data (wr_data),
            .rd_data (rd_vec[k])
        );
    end

endmodule

/* source/sweep_ctrl.sv */
module sweep_ctrl #(
    parameter  int GRID_W = 8,
    parameter  int GRID_H = 8,
    localparam int DEPTH  = GRID_W * GRID_H,
    localparam int ADDR_W = $clog2(DEPTH),
    localparam int XW     = (GRID_W > 1) ? $clog2(GRID_W) : 1,
    localparam int YW     = (GRID_H > 1) ? $clog2(GRID_H) : 1
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      run,
    input  logic [lbm_pkg::OMEGA_W-1:0]               omega,
    output logic                                      busy,
    output logic [0:lbm_pkg::NUM_DIRS-1][ADDR_W-1:0]  rd_addr,
    output logic                                      rd_valid,
    output logic [ADDR_W-1:0]                         cell_addr,
    output logic [lbm_pkg::OMEGA_W-1:0]               omega_q,
    output logic                                      step_done,
    output logic [15:0]                               step_count,
    input  logic                                      wb_valid
);

    // Lattice velocities in cell order rest, n, ne, e, se, s, sw, w, nw
    localparam int DIR_EX [lbm_pkg::NUM_DIRS] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int DIR_EY [lbm_pkg::NUM_DIRS] = '{0, 1, 1, 0, -1, -1, -1, 0, 1};

    logic              issue;
    logic [XW-1:0]     x;
    logic [YW-1:0]     y;
    logic [ADDR_W-1:0] wb_cnt;
    logic              start;
    logic [0:lbm_pkg::NUM_DIRS-1][ADDR_W-1:0] up_addr;

    // New step only from idle
    assign start = run && !busy;

    // ----------------------------------------
    // Upstream neighbours, periodic in x and y
    // ----------------------------------------

    for (genvar d = 0; d < lbm_pkg::NUM_DIRS; d++) begin : g_up
        logic [XW-1:0] ux;
        logic [YW-1:0] uy;

        // Pull from (x - ex, y - ey)
        always_comb begin
            if (DIR_EX[d] > 0) begin
                ux = (x == '0) ? XW'(GRID_W - 1) : x - 1'b1;
            end else if (DIR_EX[d] < 0) begin
                ux = (x == XW'(GRID_W - 1)) ? '0 : x + 1'b1;
            end else begin
                ux = x;
            end
            if (DIR_EY[d] > 0) begin
                uy = (y == '0) ? YW'(GRID_H - 1) : y - 1'b1;
            end else if (DIR_EY[d] < 0) begin
                uy = (y == YW'(GRID_H - 1)) ? '0 : y + 1'b1;
            end else begin
                uy = y;
            end
        end

        assign up_addr[d] = ADDR_W'(uy * GRID_W + ux);
    end

    // Last writeback of the step
    assign step_done = wb_valid && (wb_cnt == ADDR_W'(DEPTH - 1));

    // ----------------------------------------
    // Step sequencing
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            issue      <= 1'b0;
            rd_valid   <= 1'b0;
            x          <= '0;
            y          <= '0;
            wb_cnt     <= '0;
            step_count <= '0;
        end else begin
            rd_valid <= issue;
            if (start) begin
                busy  <= 1'b1;
                issue <= 1'b1;
                x     <= '0;
                y     <= '0;
            end else if (issue) begin
                // Raster order, x fastest
                if (x == XW'(GRID_W - 1)) begin
                    x <= '0;
                    if (y == YW'(GRID_H - 1)) begin
                        y     <= '0;
                        issue <= 1'b0;
                    end else begin
                        y <= y + 1'b1;
                    end
                end else begin
                    x <= x + 1'b1;
                end
            end
            if (wb_valid) begin
                wb_cnt <= step_done ? '0 : wb_cnt + 1'b1;
            end
            if (step_done) begin
                busy       <= 1'b0;
                step_count <= step_count + 1'b1;
            end
        end
    end

    // Addresses and omega for the running step
    always_ff @(posedge clk) begin
        if (start) begin
            omega_q <= omega;
        end
        if (issue) begin
            rd_addr   <= up_addr;
            cell_addr <= ADDR_W'(y * GRID_W + x);
        end
    end

endmodule

/* source/bgk_collider.sv */
module bgk_collider #(
    parameter int ADDR_W = 6
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic [ADDR_W-1:0]              in_addr,
    input  lbm_pkg::cell_t                 in_cell,
    input  logic [lbm_pkg::OMEGA_W-1:0]    omega,
    output logic                           out_valid,
    output logic [ADDR_W-1:0]              out_addr,
    output lbm_pkg::cell_t                 out_cell,
    output lbm_pkg::moments_t              out_moments
);

    localparam int N  = lbm_pkg::NUM_DIRS;
    localparam int DW = lbm_pkg::DIST_W;
    localparam int MW = lbm_pkg::MOM_W;
    localparam int OW = lbm_pkg::OMEGA_W;

    // Weight per slot in cell order with rest first and axis and diagonal alternating
    localparam logic [15:0] WEIGHT [N] = '{
        lbm_pkg::W_REST, lbm_pkg::W_AXIS, lbm_pkg::W_DIAG,
        lbm_pkg::W_AXIS, lbm_pkg::W_DIAG, lbm_pkg::W_AXIS,
        lbm_pkg::W_DIAG, lbm_pkg::W_AXIS, lbm_pkg::W_DIAG
    };

    logic [0:N-1][DW-1:0] in_vec;
    logic [MW-1:0]        rho_sum;
    logic [MW-1:0]        east_sum;
    logic [MW-1:0]        west_sum;
    logic [MW-1:0]        north_sum;
    logic [MW-1:0]        south_sum;

    logic                 s1_valid;
    logic [ADDR_W-1:0]    s1_addr;
    logic [0:N-1][DW-1:0] s1_vec;
    lbm_pkg::moments_t    s1_moments;

    logic [0:N-1][DW-1:0] new_vec;

    assign in_vec = in_cell;

    // ----------------------------------------
    // Stage 1 moments
    // ----------------------------------------

    always_comb begin
        rho_sum = '0;
        for (int d = 0; d < N; d++) begin
            rho_sum = rho_sum + in_vec[d];
        end
    end

    // Partial sums stay positive and the difference wraps into two's complement
    assign east_sum  = in_cell.ne + in_cell.e + in_cell.se;
    assign west_sum  = in_cell.nw + in_cell.w + in_cell.sw;
    assign north_sum = in_cell.n + in_cell.ne + in_cell.nw;
    assign south_sum = in_cell.s + in_cell.se + in_cell.sw;

    always_ff @(posedge clk) begin
        s1_addr          <= in_addr;
        s1_vec           <= in_vec;
        s1_moments.rho   <= rho_sum;
        s1_moments.mom_x <= east_sum - west_sum;
        s1_moments.mom_y <= north_sum - south_sum;
    end

    // ----------------------------------------
    // Stage 2 BGK relaxation
    // ----------------------------------------

    always_comb begin : relax
        logic        [MW+15:0]   eq_full;
        logic        [MW-1:0]    feq;
        logic signed [MW+1:0]    diff;
        logic signed [MW+OW+2:0] prod;
        logic signed [MW+OW+2:0] delta;
        for (int d = 0; d < N; d++) begin
            // Rest-state equilibrium is weight times density
            eq_full = s1_moments.rho * WEIGHT[d];
            feq     = eq_full[MW+15:16];
            diff    = $signed({2'b00, feq}) - $signed({{(MW + 2 - DW){1'b0}}, s1_vec[d]});
            prod    = diff * $signed({1'b0, omega});
            // omega carries eight fraction bits
            delta   = prod >>> 8;
            // Wraps to 16 bits like the stored format
            new_vec[d] = s1_vec[d] + delta[DW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        out_addr    <= s1_addr;
        out_cell    <= new_vec;
        out_moments <= s1_moments;
    end

    // Valid pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

endmodule

/* source/lbm_top.sv */
module lbm_top #(
    parameter  int GRID_W = 8,
    parameter  int GRID_H = 8,
    localparam int DEPTH  = GRID_W * GRID_H,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_valid,
    input  lbm_pkg::cell_t                load_cell,
    input  logic                          run,
    input  logic [lbm_pkg::OMEGA_W-1:0]   omega,
    output logic                          busy,
    output logic                          res_valid,
    output lbm_pkg::cell_t                res_cell,
    output lbm_pkg::moments_t             res_moments,
    output logic [15:0]                   step_count
);

    // Sweep to store
    logic [0:lbm_pkg::NUM_DIRS-1][ADDR_W-1:0] rd_addr;
    logic                                     rd_valid;
    logic [ADDR_W-1:0]                        cell_addr;
    logic                                     step_done;

    // Store to collider, aligned with the RAM read
    lbm_pkg::cell_t                           rd_cell;
    logic                                     rd_valid_q;
    logic [ADDR_W-1:0]                        cell_addr_q;

    // Collider side
    logic [lbm_pkg::OMEGA_W-1:0]              omega_q;
    logic [ADDR_W-1:0]                        res_addr;

    // Loads only reach the store between steps
    logic                                     load_en;

    assign load_en = load_valid & ~busy;

    // ----------------------------------------
    // RAM read latency match
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        cell_addr_q <= cell_addr;
    end

    // ----------------------------------------
    // Storage, sequencing, physics core
    // ----------------------------------------

    dist_store #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_en),
        .load_cell  (load_cell),
        .rd_addr    (rd_addr),
        .wb_valid   (res_valid),
        .wb_addr    (res_addr),
        .wb_cell    (res_cell),
        .step_done  (step_done),
        .rd_cell    (rd_cell)
    );

    sweep_ctrl #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) u_sweep (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .omega      (omega),
        .busy       (busy),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .cell_addr  (cell_addr),
        .omega_q    (omega_q),
        .step_done  (step_done),
        .step_count (step_count),
        .wb_valid   (res_valid)
    );

    // Results double as the writeback into the next bank
    bgk_collider #(
        .ADDR_W (ADDR_W)
    ) u_collider (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (rd_valid_q),
        .in_addr     (cell_addr_q),
        .in_cell     (rd_cell),
        .omega       (omega_q),
        .out_valid   (res_valid),
        .out_addr    (res_addr),
        .out_cell    (res_cell),
        .out_moments (res_moments)
    );

endmodule

/* test/lbm_tb_model.svh */
// ----------------------------------------
// Stimulus table
// ----------------------------------------

// Load patterns, KEEP runs on from the current state
localparam logic [1:0] PAT_KEEP   = 2'd0;
localparam logic [1:0] PAT_RAMP   = 2'd1;
localparam logic [1:0] PAT_RANDOM = 2'd2;

// One entry: load pattern, omega, number of steps, stray pulses during busy
typedef struct packed {
    logic [1:0] pattern;
    logic [9:0] omega;
    logic [7:0] steps;
    logic       stray;
} test_entry_t;

localparam int NUM_TESTS = 6;

localparam test_entry_t TEST_TABLE [NUM_TESTS] = '{
    '{PAT_RAMP,   10'd0,   8'd1, 1'b0},
    '{PAT_RANDOM, 10'd256, 8'd1, 1'b0},
    '{PAT_RANDOM, 10'd150, 8'd3, 1'b1},
    '{PAT_KEEP,   10'd77,  8'd2, 1'b0},
    '{PAT_RAMP,   10'd200, 8'd2, 1'b1},
    '{PAT_KEEP,   10'd512, 8'd1, 1'b0}
};

// Lattice velocities, order rest, n, ne, e, se, s, sw, w, nw
localparam int DIR_EX [9] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
localparam int DIR_EY [9] = '{0, 1, 1, 0, -1, -1, -1, 0, 1};

// ----------------------------------------
// Random source
// ----------------------------------------

logic [31:0] lcg_state = 32'h87ae_df5e;

// Kept below 4096 so early sums stay small
function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {4'h0, lcg_state[27:16]};
endfunction

// ----------------------------------------
// Reference model
// ----------------------------------------

// Current bank contents, per address and direction
logic [15:0] model_grid [DEPTH][9];
// Moments of the streamed cell of the last step
logic [19:0] exp_rho [DEPTH];
logic [19:0] exp_mx  [DEPTH];
logic [19:0] exp_my  [DEPTH];

function automatic longint weight_of(input int d);
    if (d == 0) begin
        return longint'(lbm_pkg::W_REST);
    end
    // Odd slots lie on the axes
    return (d % 2 == 1) ? longint'(lbm_pkg::W_AXIS) : longint'(lbm_pkg::W_DIAG);
endfunction

// Stream and collide the whole grid, model_grid then holds the new bank
task automatic model_step(input logic [9:0] w);
    longint      s [9];
    longint      rho;
    longint      mx;
    longint      my;
    longint      eq;
    longint      delta;
    logic [15:0] next_grid [DEPTH][9];
    int          ux;
    int          uy;
    int          a;
    for (int y = 0; y < GRID_H; y++) begin
        for (int x = 0; x < GRID_W; x++) begin
            a   = y * GRID_W + x;
            rho = 0;
            // Pull each direction from its upstream neighbour, periodic
            for (int d = 0; d < 9; d++) begin
                ux   = (x - DIR_EX[d] + GRID_W) % GRID_W;
                uy   = (y - DIR_EY[d] + GRID_H) % GRID_H;
                s[d] = model_grid[uy * GRID_W + ux][d];
                rho  = rho + s[d];
            end
            mx = s[2] + s[3] + s[4] - s[6] - s[7] - s[8];
            my = s[1] + s[2] + s[8] - s[4] - s[5] - s[6];
            exp_rho[a] = rho[19:0];
            exp_mx[a]  = mx[19:0];
            exp_my[a]  = my[19:0];
            // BGK toward the rest-state equilibrium
            for (int d = 0; d < 9; d++) begin
                eq    = (rho * weight_of(d)) >> 16;
                delta = ((eq - s[d]) * longint'(w)) >>> 8;
                next_grid[a][d] = 16'(s[d] + delta);
            end
        end
    end
    model_grid = next_grid;
endtask

// Reset, loads and steps with a generous margin
function automatic longint run_time_limit();
    longint total;
    total = 20 * 10;
    for (int t = 0; t < NUM_TESTS; t++) begin
        if (TEST_TABLE[t].pattern != PAT_KEEP) begin
            total = total + (DEPTH + 2) * 10;
        end
        total = total + longint'(TEST_TABLE[t].steps) * (DEPTH + 10) * 10;
    end
    return 2 * total;
endfunction

/* test/lbm_tb.sv */
module lbm_tb;

    localparam int GRID_W     = 8;
    localparam int GRID_H     = 6;
    localparam int DEPTH      = GRID_W * GRID_H;
    // Edges allowed between run and the first result
    localparam int WAIT_LIMIT = 20;

    logic                        clk;
    logic                        rst_n;
    logic                        load_valid;
    lbm_pkg::cell_t              load_cell;
    logic                        run;
    logic [lbm_pkg::OMEGA_W-1:0] omega;
    logic                        busy;
    logic                        res_valid;
    lbm_pkg::cell_t              res_cell;
    lbm_pkg::moments_t           res_moments;
    logic [15:0]                 step_count;

    int error_count = 0;
    int check_count = 0;
    int steps_done  = 0;

    `include "lbm_tb_model.svh"

    // Non-square grid so x and y mixups show
    lbm_top #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .load_cell   (load_cell),
        .run         (run),
        .omega       (omega),
        .busy        (busy),
        .res_valid   (res_valid),
        .res_cell    (res_cell),
        .res_moments (res_moments),
        .step_count  (step_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic string dir_name(input int d);
        case (d)
            0: return "rest";
            1: return "n";
            2: return "ne";
            3: return "e";
            4: return "se";
            5: return "s";
            6: return "sw";
            7: return "w";
            default: return "nw";
        endcase
    endfunction

    // Fill the current bank from address 0 and mirror it in the model
    task automatic load_grid(input logic [1:0] pattern);
        logic [0:8][15:0] vec;
        for (int a = 0; a < DEPTH; a++) begin
            for (int d = 0; d < 9; d++) begin
                // Ramp value tells address and direction apart
                if (pattern == PAT_RAMP) begin
                    vec[d] = 16'(a * 16 + d);
                end else begin
                    vec[d] = next_random();
                end
                model_grid[a][d] = vec[d];
            end
            @(posedge clk);
            #1;
            load_valid = 1'b1;
            load_cell  = vec;
        end
        @(posedge clk);
        #1;
        load_valid = 1'b0;
    endtask

    task automatic check_result(input int a);
        logic [0:8][15:0] got;
        got = res_cell;
        compare($sformatf("busy at %0d", a), busy, 1);
        for (int d = 0; d < 9; d++) begin
            compare($sformatf("res_cell.%s at %0d", dir_name(d), a), got[d], model_grid[a][d]);
        end
        compare($sformatf("res_moments.rho at %0d", a), {12'h0, res_moments.rho}, exp_rho[a]);
        compare($sformatf("res_moments.mom_x at %0d", a), {12'h0, res_moments.mom_x}, exp_mx[a]);
        compare($sformatf("res_moments.mom_y at %0d", a), {12'h0, res_moments.mom_y}, exp_my[a]);
    endtask

    // One step with optional run and load pulses while busy
    task automatic run_step(input logic [9:0] w, input logic stray);
        int edges;
        model_step(w);
        @(posedge clk);
        #1;
        run   = 1'b1;
        omega = w;
        @(posedge clk);
        #1;
        run   = 1'b0;
        // Omega must stay latched from the run edge
        omega = ~w;
        edges = 0;
        @(negedge clk);
        compare("busy after run", busy, 1);
        while (!res_valid && edges < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            if (stray && edges == 1) begin
                #1;
                run        = 1'b1;
                load_valid = 1'b1;
                load_cell  = {9{16'hdead}};
            end else if (stray && edges == 2) begin
                #1;
                run        = 1'b0;
                load_valid = 1'b0;
            end
            @(negedge clk);
        end
        if (!res_valid) begin
            error_count++;
            $display("No result arrived within %0d cycles of the run pulse", WAIT_LIMIT);
            return;
        end
        compare("res_valid latency", edges, 4);
        // Results come back to back in address order
        for (int a = 0; a < DEPTH; a++) begin
            if (a > 0) begin
                @(negedge clk);
                compare($sformatf("res_valid at %0d", a), res_valid, 1);
            end
            check_result(a);
        end
        @(negedge clk);
        steps_done++;
        compare("res_valid after step", res_valid, 0);
        compare("busy after step", busy, 0);
        compare("step_count", step_count, steps_done);
        // A stray run must not have queued a second step
        if (stray) begin
            repeat (6) begin
                @(negedge clk);
                compare("res_valid while idle", res_valid, 0);
                compare("busy while idle", busy, 0);
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin : main
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_cell  = '0;
        run        = 1'b0;
        omega      = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare("busy after reset", busy, 0);
        compare("res_valid after reset", res_valid, 0);
        compare("step_count after reset", step_count, 0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            if (TEST_TABLE[t].pattern != PAT_KEEP) begin
                load_grid(TEST_TABLE[t].pattern);
            end
            for (int s = 0; s < TEST_TABLE[t].steps; s++) begin
                run_step(TEST_TABLE[t].omega, TEST_TABLE[t].stray);
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Hard stop in case the DUT stalls
    initial begin : watchdog
        longint limit;
        limit = run_time_limit();
        #(limit);
        $display("Timeout: the run did not finish within %0d time units", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+test
source/lbm_pkg.sv
source/dist_bank_ram.sv
source/dist_store.sv
source/sweep_ctrl.sv
source/bgk_collider.sv
source/lbm_top.sv
test/lbm_tb.sv

/* Bender.yml */
package:
  name: lbm_d2q9

sources:
  - source/lbm_pkg.sv
  - source/dist_bank_ram.sv
  - source/dist_store.sv
  - source/sweep_ctrl.sv
  - source/bgk_collider.sv
  - source/lbm_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/lbm_tb.sv
